//--- list.f
hw/mole_game_pkg.sv
hw/seg_display_pkg.sv
hw/tick_gen.sv
hw/mole_spawner.sv
hw/game_controller.sv
hw/score_display.sv
hw/mole_game_top.sv
verification/mole_game_chk.sv
verification/mole_game_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the mole game testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f list.f --top-module mole_game_tb \
    -Mdir obj_dir -o mole_game_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Build failed"
    exit 1
fi

./obj_dir/mole_game_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Verification failed" sim.log; then
    exit 1
fi
if ! grep -q "Verification passed" sim.log; then
    echo "No result line found in sim.log"
    exit 1
fi
exit 0

//--- verification/mole_game_tb.sv
module mole_game_tb;

    import mole_game_pkg::*;
    import seg_display_pkg::*;

    localparam int TICK_CYCLES = 4;
    localparam int SCAN_CYCLES = 3;
    localparam int SETUP_TICKS = 12;
    localparam int GAME_TICKS  = 40;
    localparam int CYCLE_LIMIT = 4 * TICK_CYCLES * (SETUP_TICKS + 2 * GAME_TICKS + 40);

    localparam int BOX_L [5] = '{12, 41, 70, 27, 56};
    localparam int BOX_R [5] = '{23, 52, 81, 38, 67};
    localparam int BOX_T [5] = '{19, 19, 19, 47, 47};
    localparam int BOX_B [5] = '{23, 23, 23, 51, 51};
    localparam logic [6:0] SEG_TABLE [11] = '{
        7'b1000000, 7'b1111001, 7'b0100100, 7'b0110000, 7'b0011001, 7'b0010010,
        7'b0000010, 7'b1111000, 7'b0000000, 7'b0010000, 7'b0001001
    };

    typedef struct packed {
        phase_t phase;
        score_t score;
        score_t high;
    } state_t;

    logic        clk = 1'b0;
    logic        rst;
    logic        left;
    logic        right;
    logic        abort;
    difficulty_t difficulty;
    pointer_t    xpos;
    pointer_t    ypos;
    anodes_t     an;
    segments_t   seg;
    phase_t      phase;
    hole_t       hole;
    kind_t       kind;
    score_t      score;
    score_t      high_score;
    ticks_t      time_left;

    int          value_errors = 0;
    int          other_errors = 0;
    int          cycles = 0;
    logic [31:0] rng;
    state_t      expected;
    state_t      current;
    logic        pend_l;
    logic        pend_r;
    logic [10:0] disp;

    // Inputs as the DUT took them at the last rising edge
    logic        seen_rst;
    logic        seen_l;
    logic        seen_r;
    logic        seen_abort;
    pointer_t    seen_x;
    pointer_t    seen_y;

    // DUT state just before that edge
    logic        last_tick;
    hole_t       last_hole;
    kind_t       last_kind;
    ticks_t      last_time;

    mole_game_top #(
        .TICK_CYCLES(TICK_CYCLES),
        .SCAN_CYCLES(SCAN_CYCLES),
        .SETUP_TICKS(SETUP_TICKS),
        .GAME_TICKS (GAME_TICKS)
    ) mole_game_top_i (
        .clk(clk), .rst(rst), .left(left), .right(right), .abort(abort),
        .difficulty(difficulty), .xpos(xpos), .ypos(ypos), .an(an), .seg(seg),
        .phase(phase), .hole(hole), .kind(kind), .score(score),
        .high_score(high_score), .time_left(time_left)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    ///////////////////////////////////////////////////////////////////////
    // Reference model
    ///////////////////////////////////////////////////////////////////////

    function automatic state_t next_game_state(input state_t st, input logic pl, input logic pr,
                                               input pointer_t x, input pointer_t y,
                                               input hole_t h, input kind_t k,
                                               input ticks_t tl);
        state_t nx;
        int     cx;
        int     cy;
        logic   in_mole;
        logic   good;
        nx = st;
        cx = (x / 4 > 95) ? 95 : int'(x / 4);
        cy = (y / 4 > 63) ? 63 : int'(y / 4);
        in_mole = (h < 5) && cx >= BOX_L[h] && cx <= BOX_R[h] && cy >= BOX_T[h] && cy <= BOX_B[h];
        case (st.phase)
            MENU: begin
                if (pl && cx >= 23 && cx <= 70 && cy >= 32 && cy <= 51) begin
                    nx.phase = SETUP;
                    nx.score = '0;
                end
            end
            SETUP: begin
                if (tl <= 1) nx.phase = INGAME;
            end
            INGAME: begin
                if (tl == 0) begin
                    nx.phase = OVER;
                    if (st.score > st.high) nx.high = st.score;
                end else if ((pl || pr) && in_mole) begin
                    good = pl ? (k == GOOD) : (k == BAD);
                    if (good && st.score != 8'd255) nx.score = st.score + 8'd1;
                    else if (!good && st.score != 8'd0) nx.score = st.score - 8'd1;
                end
            end
            default: begin
                if (pl || pr) nx.phase = MENU;
            end
        endcase
        return nx;
    endfunction

    // Returns anodes above segments
    function automatic logic [10:0] display_pattern(input phase_t ph, input logic [1:0] idx,
                                                    input score_t sc, input score_t hi,
                                                    input ticks_t tl);
        int   sec;
        int   d;
        logic on;
        sec = tl / 4;
        on  = 1'b1;
        d   = 0;
        case (ph)
            SETUP: begin
                on = idx[1];
                d  = idx[0] ? (sec / 10) % 10 : sec % 10;
            end
            INGAME: d = (idx == 3) ? (sec / 10) % 10 : (idx == 2) ? sec % 10 :
                        (idx == 1) ? (sc / 10) % 10 : sc % 10;
            OVER:   d = (idx == 3) ? 10 : (idx == 2) ? 1 :
                        (idx == 1) ? (hi / 10) % 10 : hi % 10;
            default: on = 1'b0;
        endcase
        if (!on) return {4'b1111, 7'b1111111};
        return {~(4'b0001 << idx), SEG_TABLE[d]};
    endfunction

    task automatic check_phase(input phase_t got, input phase_t exp, input string what);
        if (got !== exp) begin
            value_errors++;
            $display("[FAIL] %0t %s: got %s, expected %s", $time, what, got.name(), exp.name());
        end
    endtask

    task automatic check_score(input score_t got, input score_t exp, input string what);
        if (got !== exp) begin
            value_errors++;
            $display("[FAIL] %0t %s: got %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_ticks(input ticks_t got, input ticks_t exp, input string what);
        if (got !== exp) begin
            value_errors++;
            $display("[FAIL] %0t %s: got %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_anodes(input anodes_t got, input anodes_t exp, input string what);
        if (got !== exp) begin
            value_errors++;
            $display("[FAIL] %0t %s: got %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_segments(input segments_t got, input segments_t exp, input string what);
        if (got !== exp) begin
            value_errors++;
            $display("[FAIL] %0t %s: got %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic note_error(input string msg);
        other_errors++;
        $display("Error at time %0t: %s", $time, msg);
    endtask

    // Inputs only change on the falling edge
    always @(posedge clk) begin
        seen_rst   = rst;
        seen_l     = left;
        seen_r     = right;
        seen_abort = abort;
        seen_x     = xpos;
        seen_y     = ypos;
    end

    // Predict the state after the last rising edge, compare, then keep a snapshot
    always @(negedge clk) begin
        if (seen_rst) begin
            pend_l = 1'b0;
            pend_r = 1'b0;
        end else begin
            if (seen_abort) begin
                expected       = current;
                expected.phase = MENU;
                pend_l         = 1'b0;
                pend_r         = 1'b0;
            end else if (last_tick) begin
                expected = next_game_state(current, pend_l, pend_r, seen_x, seen_y,
                                           last_hole, last_kind, last_time);
                pend_l   = seen_l;
                pend_r   = seen_r;
            end else begin
                expected = current;
                pend_l   = pend_l | seen_l;
                pend_r   = pend_r | seen_r;
            end
            check_phase(phase, expected.phase, "phase");
            check_score(score, expected.score, "score");
            check_score(high_score, expected.high, "high score");
        end
        disp = display_pattern(phase, mole_game_top_i.score_display_i.scan_idx, score,
                               high_score, time_left);
        check_anodes(an, disp[10:7], "anodes");
        check_segments(seg, disp[6:0], "segments");
        current   = {phase, score, high_score};
        last_tick = mole_game_top_i.game_tick;
        last_hole = hole;
        last_kind = kind;
        last_time = time_left;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Verification failed");
            $finish;
        end
    end

    ///////////////////////////////////////////////////////////////////////
    // Stimulus
    ///////////////////////////////////////////////////////////////////////

    // The strobe seen on a falling edge is the one the next rising edge acts on
    task automatic after_tick();
        while (!mole_game_top_i.game_tick) @(negedge clk);
        @(negedge clk);
    endtask

    task automatic click(input logic l, input logic r);
        @(negedge clk);
        left  = l;
        right = r;
        @(negedge clk);
        left  = 1'b0;
        right = 1'b0;
    endtask

    task automatic point_at(input hole_t h);
        xpos = pointer_t'(4 * ((BOX_L[h] + BOX_R[h]) / 2));
        ypos = pointer_t'(4 * ((BOX_T[h] + BOX_B[h]) / 2));
    endtask

    task automatic start_game();
        xpos = pointer_t'(46 * 4);
        ypos = pointer_t'(40 * 4);
        click(1'b1, 1'b0);
        after_tick();
        check_phase(phase, SETUP, "phase after play click");
        repeat (SETUP_TICKS) after_tick();
        check_phase(phase, INGAME, "phase after countdown");
        check_ticks(time_left, ticks_t'(GAME_TICKS), "time left at game start");
    endtask

    task automatic measure_life(input difficulty_t d, input int life);
        hole_t prev;
        int    n;
        difficulty = d;
        xpos = '0;
        ypos = '0;
        prev = hole;
        n = 0;
        while (hole == prev && phase == INGAME && n < 20) begin
            after_tick();
            n++;
        end
        prev = hole;
        n = 0;
        while (hole == prev && phase == INGAME && n < 20) begin
            after_tick();
            n++;
        end
        if (n != life) note_error($sformatf("mole lifetime %0d ticks, expected %0d", n, life));
    endtask

    initial begin
        hole_t prev;
        rng        = 32'd47512;
        rst        = 1'b1;
        left       = 1'b0;
        right      = 1'b0;
        abort      = 1'b0;
        difficulty = EASY;
        xpos       = '0;
        ypos       = '0;
        repeat (8) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check_phase(phase, MENU, "phase after reset");
        check_anodes(an, AN_OFF, "anodes after reset");
        check_score(score, '0, "score after reset");
        check_score(high_score, '0, "high score after reset");

        click(1'b1, 1'b0);
        after_tick();
        after_tick();
        check_phase(phase, MENU, "phase after click outside play box");

        start_game();
        for (int i = 0; i < 6; i++) begin
            prev = hole;
            point_at(hole);
            // Wrong button first, while the score is still zero
            if (i % 4 == 0 || i % 4 == 3) begin
                click(kind == BAD, kind == GOOD);
            end else begin
                click(kind == GOOD, kind == BAD);
            end
            after_tick();
            if (hole == prev) note_error("hole did not move after a hit");
        end
        // Rows above every hole, so these always miss
        repeat (3) begin
            rng  = xorshift(rng);
            xpos = pointer_t'(rng % 384);
            rng  = xorshift(rng);
            ypos = pointer_t'(rng % 64);
            click(1'b1, 1'b0);
            after_tick();
        end
        measure_life(EASY, 6);
        measure_life(MEDIUM, 4);
        measure_life(HARD, 2);

        while (phase != OVER) after_tick();
        check_ticks(time_left, '0, "time left at game over");
        click(1'b0, 1'b1);
        after_tick();
        check_phase(phase, MENU, "phase after click in game over");

        start_game();
        repeat (3) after_tick();
        abort = 1'b1;
        @(negedge clk);
        check_phase(phase, MENU, "phase after abort");
        abort = 1'b0;
        repeat (4) @(negedge clk);

        $display("Value errors: %0d, other errors: %0d", value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- verification/mole_game_chk.sv
module mole_game_chk (
    input logic                     clk,
    input logic                     rst,
    input seg_display_pkg::anodes_t an,
    input mole_game_pkg::hole_t     hole,
    input mole_game_pkg::phase_t    phase,
    input mole_game_pkg::score_t    score
);

    import mole_game_pkg::*;
    import seg_display_pkg::*;

    a_one_anode: assert property (@(posedge clk) disable iff (rst)
        (an == AN_OFF) || $onehot(~an))
        else $error("more than one anode driven");

    a_hole_range: assert property (@(posedge clk) disable iff (rst) hole < 3'd5)
        else $error("hole out of range");

    // Menu only leads to the countdown
    a_menu_exit: assert property (@(posedge clk) disable iff (rst)
        (phase == MENU) |=> (phase == MENU) || (phase == SETUP))
        else $error("menu left toward a phase other than setup");

    a_score_max: assert property (@(posedge clk) disable iff (rst) score <= 8'd200)
        else $error("score above its reachable maximum");

endmodule

bind mole_game_top mole_game_chk mole_game_chk_i (
    .clk  (clk),
    .rst  (rst),
    .an   (an),
    .hole (hole),
    .phase(phase),
    .score(score)
);

//--- hw/mole_game_top.sv
module mole_game_top #(
    parameter int TICK_CYCLES = 25_000_000,
    parameter int SCAN_CYCLES = 100_000,
    parameter int SETUP_TICKS = 12,
    parameter int GAME_TICKS  = 120
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       left,
    input  logic                       right,
    input  logic                       abort,
    input  mole_game_pkg::difficulty_t difficulty,
    input  mole_game_pkg::pointer_t    xpos,
    input  mole_game_pkg::pointer_t    ypos,
    output seg_display_pkg::anodes_t   an,
    output seg_display_pkg::segments_t seg,
    output mole_game_pkg::phase_t      phase,
    output mole_game_pkg::hole_t       hole,
    output mole_game_pkg::kind_t       kind,
    output mole_game_pkg::score_t      score,
    output mole_game_pkg::score_t      high_score,
    output mole_game_pkg::ticks_t      time_left
);

    logic game_tick;
    logic scan_tick;
    logic spawn;
    logic arm;

    tick_gen #(
        .TICK_CYCLES(TICK_CYCLES),
        .SCAN_CYCLES(SCAN_CYCLES)
    ) tick_gen_i (
        .clk      (clk),
        .rst      (rst),
        .game_tick(game_tick),
        .scan_tick(scan_tick)
    );

    mole_spawner mole_spawner_i (
        .clk  (clk),
        .rst  (rst),
        .spawn(spawn),
        .arm  (arm),
        .hole (hole),
        .kind (kind)
    );

    game_controller #(
        .SETUP_TICKS(SETUP_TICKS),
        .GAME_TICKS (GAME_TICKS)
    ) game_controller_i (
        .clk       (clk),
        .rst       (rst),
        .game_tick (game_tick),
        .left      (left),
        .right     (right),
        .abort     (abort),
        .difficulty(difficulty),
        .xpos      (xpos),
        .ypos      (ypos),
        .hole      (hole),
        .kind      (kind),
        .spawn     (spawn),
        .arm       (arm),
        .phase     (phase),
        .score     (score),
        .high_score(high_score),
        .time_left (time_left)
    );

    score_display score_display_i (
        .clk       (clk),
        .rst       (rst),
        .scan_tick (scan_tick),
        .phase     (phase),
        .score     (score),
        .high_score(high_score),
        .time_left (time_left),
        .an        (an),
        .seg       (seg)
    );

endmodule

//--- hw/score_display.sv
module score_display (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       scan_tick,
    input  mole_game_pkg::phase_t      phase,
    input  mole_game_pkg::score_t      score,
    input  mole_game_pkg::score_t      high_score,
    input  mole_game_pkg::ticks_t      time_left,
    output seg_display_pkg::anodes_t   an,
    output seg_display_pkg::segments_t seg
);

    import mole_game_pkg::*;
    import seg_display_pkg::*;

    logic [1:0] scan_idx;
    ticks_t     seconds;
    digit_t     digit;
    logic       digit_on;

    function automatic digit_t tens_of(input logic [7:0] value);
        return digit_t'((value / 8'd10) % 8'd10);
    endfunction

    function automatic digit_t units_of(input logic [7:0] value);
        return digit_t'(value % 8'd10);
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            scan_idx <= '0;
        end else if (scan_tick) begin
            scan_idx <= scan_idx + 2'd1;
        end
    end

    assign seconds = time_left / ticks_t'(TICKS_PER_SECOND);

    ////////////////////////////////////////////////////////////////////
    // Digit per scan position, 3 is leftmost
    ////////////////////////////////////////////////////////////////////

    always_comb begin
        digit    = '0;
        digit_on = 1'b0;
        case (phase)
            SETUP: begin
                digit_on = scan_idx[1];
                digit    = scan_idx[0] ? tens_of(seconds) : units_of(seconds);
            end
            INGAME: begin
                digit_on = 1'b1;
                case (scan_idx)
                    2'd3:    digit = tens_of(seconds);
                    2'd2:    digit = units_of(seconds);
                    2'd1:    digit = tens_of(score);
                    default: digit = units_of(score);
                endcase
            end
            OVER: begin
                digit_on = 1'b1;
                case (scan_idx)
                    2'd3:    digit = DIGIT_H;
                    2'd2:    digit = 4'd1;
                    2'd1:    digit = tens_of(high_score);
                    default: digit = units_of(high_score);
                endcase
            end
            default: begin
                digit_on = 1'b0;
            end
        endcase
    end

    assign an  = digit_on ? ~(anodes_t'(1) << scan_idx) : AN_OFF;
    assign seg = digit_on ? GLYPHS[digit] : '1;

endmodule

//--- hw/game_controller.sv
module game_controller #(
    parameter int SETUP_TICKS = 12,
    parameter int GAME_TICKS  = 120
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       game_tick,
    input  logic                       left,
    input  logic                       right,
    input  logic                       abort,
    input  mole_game_pkg::difficulty_t difficulty,
    input  mole_game_pkg::pointer_t    xpos,
    input  mole_game_pkg::pointer_t    ypos,
    input  mole_game_pkg::hole_t       hole,
    input  mole_game_pkg::kind_t       kind,
    output logic                       spawn,
    output logic                       arm,
    output mole_game_pkg::phase_t      phase,
    output mole_game_pkg::score_t      score,
    output mole_game_pkg::score_t      high_score,
    output mole_game_pkg::ticks_t      time_left
);

    import mole_game_pkg::*;

    pointer_t scaled_x;
    pointer_t scaled_y;
    coord_t   cur_x;
    coord_t   cur_y;
    logic     left_q;
    logic     right_q;
    logic     click;
    logic     in_play;
    logic     in_mole;
    logic     hit;
    logic     hit_good;
    logic     game_done;
    ticks_t   mole_age;
    ticks_t   lifetime;

    ////////////////////////////////////////////////////////////////////
    // Cursor and hit test
    ////////////////////////////////////////////////////////////////////

    assign scaled_x = xpos >> 2;
    assign scaled_y = ypos >> 2;
    assign cur_x = (scaled_x > pointer_t'(SCREEN_W - 1)) ? coord_t'(SCREEN_W - 1)
                                                          : coord_t'(scaled_x);
    assign cur_y = (scaled_y > pointer_t'(SCREEN_H - 1)) ? coord_t'(SCREEN_H - 1)
                                                          : coord_t'(scaled_y);

    assign in_play = (cur_x >= PLAY_LEFT) && (cur_x <= PLAY_RIGHT) &&
                     (cur_y >= PLAY_TOP) && (cur_y <= PLAY_BOTTOM);
    assign in_mole = (cur_x >= MOLE_LEFT[hole]) && (cur_x <= MOLE_RIGHT[hole]) &&
                     (cur_y >= MOLE_TOP[hole]) && (cur_y <= MOLE_BOTTOM[hole]);

    assign click     = left_q | right_q;
    assign hit       = click && in_mole;
    // Left click wins when both are pending
    assign hit_good  = left_q ? (kind == GOOD) : (kind == BAD);
    assign game_done = (time_left == '0);

    always_comb begin
        case (difficulty)
            MEDIUM:  lifetime = LIFE_MEDIUM;
            HARD:    lifetime = LIFE_HARD;
            default: lifetime = LIFE_EASY;
        endcase
    end

    assign arm   = game_tick && (phase == SETUP) && (time_left <= 8'd1);
    assign spawn = game_tick && (phase == INGAME) && !game_done &&
                   (hit || (mole_age >= lifetime - 8'd1));

    ////////////////////////////////////////////////////////////////////
    // Phase machine, timers and score
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            phase      <= MENU;
            score      <= '0;
            high_score <= '0;
            time_left  <= '0;
            mole_age   <= '0;
            left_q     <= 1'b0;
            right_q    <= 1'b0;
        end else if (abort) begin
            phase   <= MENU;
            left_q  <= 1'b0;
            right_q <= 1'b0;
        end else begin
            // Pending clicks are consumed by the tick
            if (game_tick) begin
                left_q  <= left;
                right_q <= right;
            end else begin
                left_q  <= left_q | left;
                right_q <= right_q | right;
            end

            if (game_tick) begin
                case (phase)
                    MENU: begin
                        if (left_q && in_play) begin
                            phase     <= SETUP;
                            time_left <= ticks_t'(SETUP_TICKS);
                            score     <= '0;
                        end
                    end
                    SETUP: begin
                        if (arm) begin
                            phase     <= INGAME;
                            time_left <= ticks_t'(GAME_TICKS);
                            mole_age  <= '0;
                        end else begin
                            time_left <= time_left - 8'd1;
                        end
                    end
                    INGAME: begin
                        if (game_done) begin
                            phase <= OVER;
                            if (score > high_score) begin
                                high_score <= score;
                            end
                        end else begin
                            time_left <= time_left - 8'd1;
                            mole_age  <= spawn ? '0 : mole_age + 8'd1;
                            if (hit && hit_good && (score != '1)) begin
                                score <= score + 8'd1;
                            end else if (hit && !hit_good && (score != '0)) begin
                                score <= score - 8'd1;
                            end
                        end
                    end
                    OVER: begin
                        if (click) begin
                            phase <= MENU;
                        end
                    end
                endcase
            end
        end
    end

endmodule

//--- hw/mole_spawner.sv
module mole_spawner (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 spawn,
    input  logic                 arm,
    output mole_game_pkg::hole_t hole,
    output mole_game_pkg::kind_t kind
);

    import mole_game_pkg::*;

    localparam logic [15:0] LFSR_SEED = 16'hACE1;

    logic [15:0] lfsr;
    hole_t       draw_hole;
    kind_t       draw_kind;
    hole_t       next_hole;
    kind_t       next_kind;
    hole_t       step_hole;

    // x^16 + x^14 + x^13 + x^11
    always_ff @(posedge clk) begin
        if (rst) begin
            lfsr <= LFSR_SEED;
        end else begin
            lfsr <= {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
        end
    end

    assign draw_hole = hole_t'(lfsr % NUM_HOLES);
    assign draw_kind = lfsr[0];

    // Never show the same hole twice in a row
    always_comb begin
        if (next_hole != hole) begin
            step_hole = next_hole;
        end else if (hole == hole_t'(NUM_HOLES - 1)) begin
            step_hole = '0;
        end else begin
            step_hole = hole + 3'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            hole      <= '0;
            kind      <= GOOD;
            next_hole <= '0;
            next_kind <= GOOD;
        end else if (arm) begin
            hole <= draw_hole;
            kind <= draw_kind;
        end else if (spawn) begin
            hole      <= step_hole;
            kind      <= next_kind;
            next_hole <= draw_hole;
            next_kind <= draw_kind;
        end
    end

endmodule

//--- hw/tick_gen.sv
module tick_gen #(
    parameter int TICK_CYCLES = 25_000_000,
    parameter int SCAN_CYCLES = 100_000
) (
    input  logic clk,
    input  logic rst,
    output logic game_tick,
    output logic scan_tick
);

    localparam int PERIODS [2] = '{TICK_CYCLES, SCAN_CYCLES};

    logic [1:0] strobe;

    // One divider per strobe, 0 is the game tick
    for (genvar i = 0; i < 2; i++) begin : g_div
        localparam int W = (PERIODS[i] > 1) ? $clog2(PERIODS[i]) : 1;
        localparam logic [W-1:0] LAST = W'(PERIODS[i] - 1);

        logic [W-1:0] cnt;

        always_ff @(posedge clk) begin
            if (rst) begin
                cnt <= '0;
            end else if (strobe[i]) begin
                cnt <= '0;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end

        assign strobe[i] = (cnt == LAST);
    end

    assign game_tick = strobe[0];
    assign scan_tick = strobe[1];

endmodule

//--- hw/seg_display_pkg.sv
package seg_display_pkg;

    typedef logic [3:0] digit_t;
    typedef logic [6:0] segments_t;
    typedef logic [3:0] anodes_t;

    localparam digit_t  DIGIT_H = 4'd10;
    localparam anodes_t AN_OFF  = 4'b1111;

    // Active low, bit 6 is segment g
    localparam segments_t GLYPHS [11] = '{
        7'b1000000,
        7'b1111001,
        7'b0100100,
        7'b0110000,
        7'b0011001,
        7'b0010010,
        7'b0000010,
        7'b1111000,
        7'b0000000,
        7'b0010000,
        7'b0001001
    };

endpackage

//--- hw/mole_game_pkg.sv
package mole_game_pkg;

    typedef enum logic [1:0] {
        MENU,
        SETUP,
        INGAME,
        OVER
    } phase_t;

    typedef enum logic [1:0] {
        EASY,
        MEDIUM,
        HARD
    } difficulty_t;

    typedef logic [2:0]  hole_t;
    typedef logic        kind_t;
    typedef logic [6:0]  coord_t;
    typedef logic [11:0] pointer_t;
    typedef logic [7:0]  score_t;
    typedef logic [7:0]  ticks_t;

    localparam kind_t GOOD = 1'b0;
    localparam kind_t BAD  = 1'b1;

    localparam int NUM_HOLES        = 5;
    localparam int TICKS_PER_SECOND = 4;
    localparam int SCREEN_W         = 96;
    localparam int SCREEN_H         = 64;

    // Mole hit boxes, top row first
    localparam coord_t MOLE_LEFT   [NUM_HOLES] = '{7'd12, 7'd41, 7'd70, 7'd27, 7'd56};
    localparam coord_t MOLE_RIGHT  [NUM_HOLES] = '{7'd23, 7'd52, 7'd81, 7'd38, 7'd67};
    localparam coord_t MOLE_TOP    [NUM_HOLES] = '{7'd19, 7'd19, 7'd19, 7'd47, 7'd47};
    localparam coord_t MOLE_BOTTOM [NUM_HOLES] = '{7'd23, 7'd23, 7'd23, 7'd51, 7'd51};

    // Menu play region
    localparam coord_t PLAY_LEFT   = 7'd23;
    localparam coord_t PLAY_RIGHT  = 7'd70;
    localparam coord_t PLAY_TOP    = 7'd32;
    localparam coord_t PLAY_BOTTOM = 7'd51;

    // Mole lifetime in game ticks
    localparam ticks_t LIFE_EASY   = 8'd6;
    localparam ticks_t LIFE_MEDIUM = 8'd4;
    localparam ticks_t LIFE_HARD   = 8'd2;

endpackage
